// ==== Makefile ====
# Verilator flow for the tx sample buffer

VERILATOR  ?= verilator
TOP        ?= pipe_tx_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps
PASS_MSG   ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+include
hw/pipe_tx_pkg.sv
hw/fifo_rd_if.sv
hw/tx_fifo_mem.sv
hw/tx_wr_ptr.sv
hw/tx_rd_ptr.sv
hw/tx_block_ctrl.sv
hw/pipe_tx.sv
tb/pipe_tx_asserts.sv
tb/pipe_tx_tb.sv

// ==== hw/fifo_rd_if.sv ====
`timescale 1ns/10ps

// read side of the fifo as seen by the block controller
interface fifo_rd_if;

    // status from the read pointer logic
    logic empty;
    logic ready_lvl;
    logic almost_full;

    // single cycle pop strobe
    logic pop;
    // pop is a host read, not a discard
    logic emit;

    // pointer side owns the flags
    modport status (
        output empty,
        output ready_lvl,
        output almost_full,
        input  pop,
        input  emit
    );

    // controller side owns the pop
    modport ctrl (
        input  empty,
        input  ready_lvl,
        input  almost_full,
        output pop,
        output emit
    );

endinterface

// ==== hw/pipe_tx.sv ====
`timescale 1ns/10ps

module pipe_tx (
    input  logic                 rd_clk,
    input  logic                 wr_clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  pipe_tx_pkg::pt_word_t din,
    input  logic                 rd_en,
    output logic                 rd_ready,
    output pipe_tx_pkg::pt_word_t dout,
    output logic                 dout_valid
);

    import pipe_tx_pkg::*;

    // write side to ram and read pointer
    logic     we;
    pt_addr_t waddr;
    pt_ptr_t  wr_gray;

    // read side to ram and write pointer
    pt_addr_t raddr;
    pt_ptr_t  rd_gray;

    // status and pop between pointer and controller
    fifo_rd_if fifo_rd ();

    ////////////////////
    // datapath
    ////////////////////

    tx_fifo_mem u_mem (
        .wr_clk (wr_clk),
        .we     (we),
        .waddr  (waddr),
        .wdata  (din),
        .rd_clk (rd_clk),
        .raddr  (raddr),
        .rdata  (dout)
    );

    tx_wr_ptr u_wr_ptr (
        .wr_clk  (wr_clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .rd_gray (rd_gray),
        .we      (we),
        .waddr   (waddr),
        .wr_gray (wr_gray)
    );

    tx_rd_ptr u_rd_ptr (
        .rd_clk     (rd_clk),
        .rst        (rst),
        .wr_gray    (wr_gray),
        .st         (fifo_rd.status),
        .raddr      (raddr),
        .rd_gray    (rd_gray),
        .dout_valid (dout_valid)
    );

    ////////////////////
    // control
    ////////////////////

    tx_block_ctrl u_ctrl (
        .rd_clk   (rd_clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .fc       (fifo_rd.ctrl),
        .rd_ready (rd_ready)
    );

endmodule

// ==== hw/pipe_tx_pkg.sv ====
`include "pipe_tx_defs.svh"

package pipe_tx_pkg;

    ////////////////////
    // datapath widths
    ////////////////////

    // one sample word
    typedef logic [`PT_DATA_W-1:0] pt_word_t;

    // binary or gray pointer, one wrap bit above the address
    typedef logic [`PT_ADDR_W:0] pt_ptr_t;

    // ram address
    typedef logic [`PT_ADDR_W-1:0] pt_addr_t;

    // fill level, 0 up to full depth
    typedef logic [`PT_ADDR_W:0] pt_level_t;

    // reads accepted inside a block
    typedef logic [$clog2(`PT_BLOCK_LEN)-1:0] pt_count_t;

    ////////////////////
    // block control fsm
    ////////////////////

    typedef enum logic {
        ST_WAIT,
        ST_READ
    } pt_state_t;

endpackage

// ==== hw/tx_block_ctrl.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module tx_block_ctrl (
    input  logic   rd_clk,
    input  logic   rst,
    input  logic   rd_en,
    fifo_rd_if.ctrl fc,
    output logic   rd_ready
);

    import pipe_tx_pkg::*;

    pt_state_t state;
    pt_state_t state_next;

    // accepted host reads in this block
    pt_count_t rd_count;

    // host read that actually removes a word
    logic      rd_accept;
    logic      last_read;

    assign rd_accept = (state == ST_READ) && rd_en && !fc.empty;
    assign last_read = rd_accept && (rd_count == pt_count_t'(`PT_BLOCK_LEN-1));

    ////////////////////
    // pop decision
    ////////////////////

    always_comb begin
        fc.pop  = 1'b0;
        fc.emit = 1'b0;
        case (state)
            ST_WAIT: begin
                // keep only the freshest data while idle
                fc.pop = (fc.ready_lvl || fc.almost_full) && !fc.empty;
            end
            ST_READ: begin
                // pops follow host reads only
                fc.pop  = rd_accept;
                fc.emit = rd_accept;
            end
            default: begin
                fc.pop  = 1'b0;
                fc.emit = 1'b0;
            end
        endcase
    end

    ////////////////////
    // block fsm
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            // first host read at ready opens a block
            ST_WAIT: if (rd_en && rd_ready) state_next = ST_READ;
            ST_READ: if (last_read) state_next = ST_WAIT;
            default: state_next = ST_WAIT;
        endcase
    end

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            state    <= ST_WAIT;
            rd_count <= '0;
            rd_ready <= 1'b0;
        end else begin
            state    <= state_next;
            // registered copy of the level compare
            rd_ready <= fc.ready_lvl;
            if (state != ST_READ || last_read) begin
                rd_count <= '0;
            end else if (rd_accept) begin
                rd_count <= rd_count + pt_count_t'(1);
            end
        end
    end

endmodule

// ==== hw/tx_fifo_mem.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module tx_fifo_mem (
    input  logic                 wr_clk,
    input  logic                 we,
    input  pipe_tx_pkg::pt_addr_t waddr,
    input  pipe_tx_pkg::pt_word_t wdata,
    input  logic                 rd_clk,
    input  pipe_tx_pkg::pt_addr_t raddr,
    output pipe_tx_pkg::pt_word_t rdata
);

    import pipe_tx_pkg::*;

    localparam int DEPTH = 1 << `PT_ADDR_W;

    // sample storage, inferred as block ram
    pt_word_t mem [0:DEPTH-1];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge wr_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // registered read every cycle
    always_ff @(posedge rd_clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/tx_rd_ptr.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module tx_rd_ptr (
    input  logic                 rd_clk,
    input  logic                 rst,
    input  pipe_tx_pkg::pt_ptr_t  wr_gray,
    fifo_rd_if.status            st,
    output pipe_tx_pkg::pt_addr_t raddr,
    output pipe_tx_pkg::pt_ptr_t  rd_gray,
    output logic                 dout_valid
);

    import pipe_tx_pkg::*;

    // write pointer crossing
    pt_ptr_t   wr_gray_meta;
    pt_ptr_t   wr_gray_sync;
    pt_ptr_t   wr_bin_sync;

    // read pointer
    pt_ptr_t   rd_bin;
    pt_ptr_t   rd_bin_next;

    pt_level_t level;

    ////////////////////
    // write pointer sync
    ////////////////////

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    // gray to binary, msb down
    always_comb begin
        wr_bin_sync[`PT_ADDR_W] = wr_gray_sync[`PT_ADDR_W];
        for (int i = `PT_ADDR_W-1; i >= 0; i--) begin
            wr_bin_sync[i] = wr_bin_sync[i+1] ^ wr_gray_sync[i];
        end
    end

    ////////////////////
    // level and flags
    ////////////////////

    // wrap bit makes the difference exact
    assign level = pt_level_t'(wr_bin_sync - rd_bin);

    assign st.empty       = (level == '0);
    assign st.ready_lvl   = (level >= pt_level_t'(`PT_READY_LVL));
    assign st.almost_full = (level >= pt_level_t'(`PT_AFULL_LVL));

    ////////////////////
    // read pointer
    ////////////////////

    assign rd_bin_next = st.pop ? rd_bin + pt_ptr_t'(1) : rd_bin;

    // head word address, ram output holds it the cycle after a pop
    assign raddr = rd_bin[`PT_ADDR_W-1:0];

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            // gray copy for the write side
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    // only host reads mark the output, discards stay silent
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= st.pop && st.emit;
        end
    end

endmodule

// ==== hw/tx_wr_ptr.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module tx_wr_ptr (
    input  logic                 wr_clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  pipe_tx_pkg::pt_ptr_t  rd_gray,
    output logic                 we,
    output pipe_tx_pkg::pt_addr_t waddr,
    output pipe_tx_pkg::pt_ptr_t  wr_gray
);

    import pipe_tx_pkg::*;

    // reset retimed into wr_clk
    logic    rst_meta;
    logic    rst_sync;

    // read pointer crossing
    pt_ptr_t rd_gray_meta;
    pt_ptr_t rd_gray_sync;

    // binary write pointer and its successor
    pt_ptr_t wr_bin;
    pt_ptr_t wr_bin_next;
    pt_ptr_t wr_gray_next;

    logic    full;

    ////////////////////
    // synchronizers
    ////////////////////

    // two flops for the rd_clk reset
    always_ff @(posedge wr_clk) begin
        rst_meta <= rst;
        rst_sync <= rst_meta;
    end

    // two flops for the gray read pointer
    always_ff @(posedge wr_clk) begin
        if (rst_sync) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    ////////////////////
    // full and write
    ////////////////////

    // full when the top two gray bits differ and the rest match
    assign full = (wr_gray == {~rd_gray_sync[`PT_ADDR_W -: 2],
                               rd_gray_sync[`PT_ADDR_W-2:0]});

    // writes into a full fifo are dropped
    assign we    = wr_en && !full;
    assign waddr = wr_bin[`PT_ADDR_W-1:0];

    assign wr_bin_next  = wr_bin + pt_ptr_t'(1);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    always_ff @(posedge wr_clk) begin
        if (rst_sync) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (we) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

endmodule

// ==== include/pipe_tx_defs.svh ====
`ifndef PIPE_TX_DEFS_SVH
`define PIPE_TX_DEFS_SVH

////////////////////
// sizes for the tx sample buffer
////////////////////

// sample word width
`define PT_DATA_W     16

// fifo address bits, depth is 2**PT_ADDR_W
`define PT_ADDR_W     6

// fill level that raises rd_ready
`define PT_READY_LVL  32

// almost full level, forces a discard
`define PT_AFULL_LVL  60

// words per host block, kept below the ready level
`define PT_BLOCK_LEN  16

`endif

// ==== tb/pipe_tx_asserts.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module pipe_tx_asserts (
    input logic                   rd_clk,
    input logic                   rst,
    input logic                   pop,
    input logic                   emit,
    input logic                   empty,
    input pipe_tx_pkg::pt_state_t state
);

    import pipe_tx_pkg::*;

    // host reads taken since the block opened
    int reads_in_block;
    // failure count, picked up by the testbench at the end
    int fail_cnt = 0;

    always_ff @(posedge rd_clk) begin
        if (rst || state != ST_READ) begin
            reads_in_block <= 0;
        end else if (pop && emit) begin
            reads_in_block <= reads_in_block + 1;
        end
    end

    ////////////////////
    // pop protocol
    ////////////////////

    // never pop an empty fifo
    pop_not_empty: assert property (@(posedge rd_clk) disable iff (rst) pop |-> !empty)
        else begin
            fail_cnt++;
            $error("pop while the fifo is empty");
        end

    // emit only qualifies a pop
    emit_with_pop: assert property (@(posedge rd_clk) disable iff (rst) emit |-> pop)
        else begin
            fail_cnt++;
            $error("emit without pop");
        end

    ////////////////////
    // block length
    ////////////////////

    // fsm must drop back to wait on the last read
    block_ends: assert property (@(posedge rd_clk) disable iff (rst)
        (state == ST_READ) |-> (reads_in_block < `PT_BLOCK_LEN))
        else begin
            fail_cnt++;
            $error("block still open after %0d reads", reads_in_block);
        end

endmodule

bind tx_block_ctrl pipe_tx_asserts u_asserts (
    .rd_clk (rd_clk),
    .rst    (rst),
    .pop    (fc.pop),
    .emit   (fc.emit),
    .empty  (fc.empty),
    .state  (state)
);

// ==== tb/pipe_tx_tb.sv ====
`timescale 1ns/10ps

`include "pipe_tx_defs.svh"

module pipe_tx_tb;

    import pipe_tx_pkg::*;

    localparam int DEPTH       = 1 << `PT_ADDR_W;
    localparam int NUM_BLOCKS  = 20;
    localparam int CYC_PER_BLK = 200;
    localparam int TIMEOUT_CYC = NUM_BLOCKS * CYC_PER_BLK;
    // idle long enough to cycle the whole fifo a few times
    localparam int LONG_IDLE   = 3 * DEPTH;
    localparam int PROBE_CYC   = 8;
    localparam int SEED        = 10;

    logic     rd_clk = 1'b0;
    logic     wr_clk = 1'b0;
    logic     rst;
    logic     wr_en;
    pt_word_t din;
    logic     rd_en;
    logic     rd_ready;
    pt_word_t dout;
    logic     dout_valid;

    // reference model of every value the producer wrote
    bit written [int];
    int wr_value;
    int last_written;
    // last word seen on dout
    int last_out;

    int checks     = 0;
    int mismatches = 0;
    int other_errs = 0;
    int cycles     = 0;

    pipe_tx uut (
        .rd_clk     (rd_clk),
        .wr_clk     (wr_clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .din        (din),
        .rd_en      (rd_en),
        .rd_ready   (rd_ready),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    ////////////////////
    // clocks
    ////////////////////

    always #10 rd_clk = ~rd_clk;

    // write clock 7 ns behind
    always begin
        #7;
        forever #10 wr_clk = ~wr_clk;
    end

    // hang guard
    always @(posedge rd_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            other_errs++;
            $display("timeout: run did not finish within %0d rd_clk cycles", TIMEOUT_CYC);
            finish_run();
        end
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_dout(input int exp);
        checks++;
        assert (dout === pt_word_t'(exp)) else begin
            mismatches++;
            $display("mismatch dout: got %h expected %h", dout, pt_word_t'(exp));
        end
    endtask

    task automatic check_written(input int word);
        checks++;
        assert (written.exists(word)) else begin
            other_errs++;
            $display("dout value %h was never written", word);
        end
    endtask

    // head of a new block must be fresh and above the last output
    task automatic check_block_head(input int word, input int start_last);
        checks++;
        assert (word >= start_last - DEPTH) else begin
            other_errs++;
            $display("stale first word %h, newest written at start %h", word, start_last);
        end
        checks++;
        assert (word > last_out) else begin
            other_errs++;
            $display("block head %h is not above previous output %h", word, last_out);
        end
    endtask

    task automatic finish_run();
        other_errs += uut.u_ctrl.u_asserts.fail_cnt;
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    ////////////////////
    // host side
    ////////////////////

    // one quiet host cycle where discards must stay silent
    task automatic quiet_cycle();
        @(negedge rd_clk);
        check_bit("dout_valid", dout_valid, 1'b0);
    endtask

    task automatic run_block(input int blk);
        int idle;
        int start_last;
        int pulses;
        int word;
        int i;
        idle = (blk % 4 == 3) ? LONG_IDLE : $urandom_range(0, 32);
        repeat (idle) quiet_cycle();
        while (rd_ready !== 1'b1) quiet_cycle();
        // first read at ready opens the block
        start_last = last_written;
        rd_en      = 1'b1;
        pulses     = 0;
        while (pulses < `PT_BLOCK_LEN) begin
            @(negedge rd_clk);
            if (dout_valid === 1'b1) begin
                word = int'(dout);
                check_written(word);
                if (pulses == 0) begin
                    check_block_head(word, start_last);
                end else begin
                    // no discards inside a block
                    check_dout(last_out + 1);
                end
                last_out = word;
                pulses++;
            end
            rd_en = (pulses < `PT_BLOCK_LEN);
        end
        // reads with rd_ready low after the block give nothing
        for (i = 0; i < PROBE_CYC; i++) begin
            @(negedge rd_clk);
            check_bit("dout_valid", dout_valid, 1'b0);
            rd_en = (i < PROBE_CYC - 1) && !rd_ready;
        end
    endtask

    initial begin
        int blk;
        void'($urandom(SEED));
        rst      = 1'b1;
        rd_en    = 1'b0;
        last_out = -1;
        repeat (5) @(posedge rd_clk);
        @(negedge rd_clk);
        rst = 1'b0;
        @(negedge rd_clk);
        check_bit("rd_ready", rd_ready, 1'b0);
        check_bit("dout_valid", dout_valid, 1'b0);
        for (blk = 0; blk < NUM_BLOCKS; blk++) begin
            run_block(blk);
        end
        finish_run();
    end

    ////////////////////
    // producer side
    ////////////////////

    // counting samples at about half rate
    initial begin
        wr_en        = 1'b0;
        din          = '0;
        wr_value     = 0;
        last_written = -1;
        @(negedge rst);
        // wait out the write-side reset sync
        repeat (4) @(negedge wr_clk);
        forever begin
            @(negedge wr_clk);
            wr_en = ($urandom_range(0, 1) == 1);
            if (wr_en) begin
                din               = pt_word_t'(wr_value);
                written[wr_value] = 1'b1;
                last_written      = wr_value;
                wr_value++;
            end
        end
    end

endmodule
